//--- verilog/snakeGeomPkg.sv
// snake geometry package with screen, tile and coordinate types and start positions
package snakeGeomPkg;

    // frame buffer size in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;
    // edge of a square tile
    localparam int TileSize = 10;
    localparam int SnakeLength = 6;

    typedef logic [7:0] xCoordT;
    typedef logic [6:0] yCoordT;
    // column or row inside one tile
    typedef logic [3:0] tileOffsetT;
    // segment number, 0 is the head
    typedef logic [2:0] segIndexT;
    typedef logic [2:0] colourT;

    typedef struct packed {
        xCoordT x;
        yCoordT y;
    } pointT;

    localparam pointT StartHead = '{x: 8'd80, y: 7'd60};
    // vertical snake, tail toward the bottom edge
    localparam pointT StartBody [SnakeLength] = '{
        StartHead,
        '{x: 8'd80, y: 7'd70},
        '{x: 8'd80, y: 7'd80},
        '{x: 8'd80, y: 7'd90},
        '{x: 8'd80, y: 7'd100},
        '{x: 8'd80, y: 7'd110}
    };

    localparam pointT AppleOrigin = '{x: 8'd30, y: 7'd30};
    localparam colourT AppleColour = 3'b100;
    // black
    localparam colourT EraseColour = 3'b000;

endpackage

//--- verilog/snakeCtrlPkg.sv
// snake control package with sequencer state, heading, paint mode and pixel write types
package snakeCtrlPkg;

    import snakeGeomPkg::*;

    // game sequencer states
    typedef enum logic [3:0] {
        StIdle,
        StWaitDraw,
        StApple,
        StBody,
        StWaitErase,
        StErase,
        StCheck,
        StOver
    } seqStateT;

    // snake heading
    typedef enum logic [1:0] {
        DirUp,
        DirDown,
        DirLeft,
        DirRight
    } directionT;

    // what the painter is drawing
    typedef enum logic [1:0] {
        PaintIdle,
        PaintApple,
        PaintBody,
        PaintErase
    } paintModeT;

    // one frame buffer write
    typedef struct packed {
        xCoordT x;
        yCoordT y;
        colourT colour;
    } pixelT;

endpackage

//--- verilog/frameTimer.sv
// frame timer producing a one-cycle animation tick every TickPeriod cycles
`timescale 1ns/1ps

module frameTimer #(
    parameter int TickPeriod = 1000000
) (
    input  logic Clock,
    input  logic reset,
    output logic tick
);

    // at least one bit even for tiny periods
    localparam int CountWidth = (TickPeriod > 1) ? $clog2(TickPeriod) : 1;

    logic [CountWidth-1:0] count;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            count <= '0;
            tick <= 1'b0;
        end
        else if (count == CountWidth'(TickPeriod - 1))
        begin
            // wrap and pulse
            count <= '0;
            tick <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- verilog/tileScanner.sv
// tile scanner walking the columns and rows of one tile, one pixel per cycle
`timescale 1ns/1ps

module tileScanner
    import snakeGeomPkg::*;
(
    input  logic       Clock,
    input  logic       reset,
    input  logic       scanStart,
    output tileOffsetT col,
    output tileOffsetT row,
    output logic       scanValid,
    output logic       scanLast
);

    localparam tileOffsetT LastOffset = tileOffsetT'(TileSize - 1);

    // final pixel of the tile, bottom right corner
    assign scanLast = scanValid && (col == LastOffset) && (row == LastOffset);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            col <= '0;
            row <= '0;
            scanValid <= 1'b0;
        end
        else if (scanStart)
        begin
            // start wins over stop so back-to-back tiles have no gap
            col <= '0;
            row <= '0;
            scanValid <= 1'b1;
        end
        else if (scanLast)
        begin
            scanValid <= 1'b0;
        end
        else if (scanValid)
        begin
            // column runs fastest
            if (col == LastOffset)
            begin
                col <= '0;
                row <= row + 1'b1;
            end
            else
            begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

//--- verilog/snakeBody.sv
// snake body store with heading register, next-head and collision logic
`timescale 1ns/1ps

module snakeBody
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
(
    input  logic      Clock,
    input  logic      reset,
    input  logic      dirValid,
    input  directionT dirReq,
    input  logic      advance,
    input  segIndexT  segIndex,
    output pointT     segOrigin,
    output logic      collide
);

    // highest legal tile origins
    localparam xCoordT MaxX = xCoordT'(ScreenWidth - TileSize);
    localparam yCoordT MaxY = yCoordT'(ScreenHeight - TileSize);

    pointT segs [SnakeLength];
    directionT heading;
    pointT nextHead;

    assign segOrigin = segs[segIndex];

    // head moved one tile, a step past 0 wraps high and fails the bounds test below
    always_comb
    begin
        nextHead = segs[0];
        case (heading)
            DirUp: nextHead.y = segs[0].y - yCoordT'(TileSize);
            DirDown: nextHead.y = segs[0].y + yCoordT'(TileSize);
            DirLeft: nextHead.x = segs[0].x - xCoordT'(TileSize);
            default: nextHead.x = segs[0].x + xCoordT'(TileSize);
        endcase
    end

    always_comb
    begin
        collide = (nextHead.x > MaxX) || (nextHead.y > MaxY);
        // tail tile moves away on the same step
        for (int k = 0; k < SnakeLength - 1; k++)
        begin
            if (nextHead == segs[k])
                collide = 1'b1;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segs <= StartBody;
            heading <= DirUp;
        end
        else
        begin
            // latest request wins
            if (dirValid)
                heading <= dirReq;
            if (advance)
            begin
                // shift toward the tail, new head at the front
                for (int k = SnakeLength - 1; k > 0; k--)
                    segs[k] <= segs[k-1];
                segs[0] <= nextHead;
            end
        end
    end

endmodule

//--- verilog/tilePainter.sv
// tile painter forming the registered pixel write from origin, offset and paint mode
`timescale 1ns/1ps

module tilePainter
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
(
    input  logic       Clock,
    input  logic       reset,
    input  paintModeT  paintMode,
    input  pointT      segOrigin,
    input  tileOffsetT col,
    input  tileOffsetT row,
    input  logic       scanValid,
    input  colourT     snakeColour,
    output pixelT      pixel,
    output logic       plot
);

    pointT origin;
    colourT colour;

    // origin and colour per mode
    always_comb
    begin
        origin = segOrigin;
        colour = EraseColour;
        case (paintMode)
            PaintApple:
            begin
                origin = AppleOrigin;
                colour = AppleColour;
            end
            PaintBody: colour = snakeColour;
            default: colour = EraseColour;
        endcase
    end

    // write data only, qualified by plot
    always_ff @(posedge Clock)
    begin
        pixel.x <= origin.x + xCoordT'(col);
        pixel.y <= origin.y + yCoordT'(row);
        pixel.colour <= colour;
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            plot <= 1'b0;
        else
            plot <= scanValid;
    end

endmodule

//--- verilog/snakeSequencer.sv
// game sequencer FSM ordering draw, wait, erase and move with a segment counter
`timescale 1ns/1ps

module snakeSequencer
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
(
    input  logic      Clock,
    input  logic      reset,
    input  logic      start,
    input  logic      tick,
    input  logic      scanLast,
    input  logic      collide,
    output logic      scanStart,
    output paintModeT paintMode,
    output segIndexT  segIndex,
    output logic      advance,
    output logic      gameOver
);

    seqStateT state;
    seqStateT nextState;
    segIndexT segCount;
    segIndexT nextCount;
    logic lastSeg;

    assign lastSeg = (segCount == segIndexT'(SnakeLength - 1));
    assign segIndex = segCount;
    assign gameOver = (state == StOver);

    always_comb
    begin
        nextState = state;
        nextCount = segCount;
        scanStart = 1'b0;
        advance = 1'b0;
        case (state)
            StIdle:
                if (start)
                    nextState = StWaitDraw;
            StWaitDraw:
                if (tick)
                begin
                    nextState = StApple;
                    scanStart = 1'b1;
                end
            // apple tile, then straight into segment 0
            StApple:
                if (scanLast)
                begin
                    nextState = StBody;
                    scanStart = 1'b1;
                end
            StBody, StErase:
                if (scanLast)
                begin
                    // restart the scanner until segment 5 is done
                    scanStart = !lastSeg;
                    nextCount = lastSeg ? '0 : segCount + 1'b1;
                    if (lastSeg)
                        nextState = (state == StBody) ? StWaitErase : StCheck;
                end
            StWaitErase:
                if (tick)
                begin
                    nextState = StErase;
                    scanStart = 1'b1;
                end
            // one cycle to decide move or stop
            StCheck:
                if (collide)
                    nextState = StOver;
                else
                begin
                    advance = 1'b1;
                    scanStart = 1'b1;
                    nextState = StApple;
                end
            // stays here until reset
            StOver: nextState = StOver;
            default: nextState = StIdle;
        endcase
    end

    always_comb
    begin
        case (state)
            StApple: paintMode = PaintApple;
            StBody: paintMode = PaintBody;
            StErase: paintMode = PaintErase;
            default: paintMode = PaintIdle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= StIdle;
            segCount <= '0;
        end
        else
        begin
            state <= nextState;
            segCount <= nextCount;
        end
    end

endmodule

//--- verilog/snakeGame.sv
// snake game engine top level producing pixel writes for a 160x120 frame buffer
`timescale 1ns/1ps

module snakeGame
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
#(
    parameter int TickPeriod = 1000000
) (
    input  logic      Clock,
    input  logic      reset,
    input  logic      start,
    input  logic      dirValid,
    input  directionT dirReq,
    input  colourT    snakeColour,
    output pixelT     pixel,
    output logic      plot,
    output logic      gameOver
);

    logic tick;
    logic scanStart;
    logic scanValid;
    logic scanLast;
    tileOffsetT col;
    tileOffsetT row;
    paintModeT paintMode;
    segIndexT segIndex;
    pointT segOrigin;
    logic advance;
    logic collide;

    // animation pace
    frameTimer #(.TickPeriod(TickPeriod)) u_frameTimer (
        .Clock(Clock), .reset(reset), .tick(tick)
    );

    tileScanner u_tileScanner (
        .Clock(Clock), .reset(reset), .scanStart(scanStart),
        .col(col), .row(row), .scanValid(scanValid), .scanLast(scanLast)
    );

    snakeBody u_snakeBody (
        .Clock(Clock), .reset(reset), .dirValid(dirValid), .dirReq(dirReq),
        .advance(advance), .segIndex(segIndex), .segOrigin(segOrigin), .collide(collide)
    );

    // one cycle behind the scanner
    tilePainter u_tilePainter (
        .Clock(Clock), .reset(reset), .paintMode(paintMode), .segOrigin(segOrigin),
        .col(col), .row(row), .scanValid(scanValid), .snakeColour(snakeColour),
        .pixel(pixel), .plot(plot)
    );

    snakeSequencer u_snakeSequencer (
        .Clock(Clock), .reset(reset), .start(start), .tick(tick), .scanLast(scanLast),
        .collide(collide), .scanStart(scanStart), .paintMode(paintMode),
        .segIndex(segIndex), .advance(advance), .gameOver(gameOver)
    );

endmodule

//--- tests/snakeGameTb.sv
// snake game testbench checking draw, erase, steering and game over against a step file
`timescale 1ns/1ps

module snakeGameTb
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
();

    localparam int TickPeriod = 1024;
    localparam int MaxSteps = 32;
    // pixels in one tile
    localparam int TilePixels = TileSize * TileSize;

    logic Clock = 1'b0;
    logic reset;
    logic start;
    logic dirValid;
    directionT dirReq;
    colourT snakeColour;
    pixelT pixel;
    logic plot;
    logic gameOver;

    // four hex words per step for heading, head x, head y and gameOver
    logic [7:0] stepData [4*MaxSteps];
    int stepCount;
    logic stepsLoaded = 1'b0;
    int watchdogCycles;
    int errorCount = 0;
    int checkCount = 0;
    // captured writes of the current pass
    int capX [700];
    int capY [700];
    int capC [700];
    // expected tile origins with the head at index 0
    int tileX [SnakeLength];
    int tileY [SnakeLength];

    snakeGame #(.TickPeriod(TickPeriod)) u_snakeGame (
        .Clock(Clock), .reset(reset), .start(start), .dirValid(dirValid),
        .dirReq(dirReq), .snakeColour(snakeColour), .pixel(pixel), .plot(plot),
        .gameOver(gameOver)
    );

    always #10 Clock = ~Clock;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
            errorCount++;
        end
    endtask

    task automatic loadSteps();
        // unused entries keep a marker with the top bit set
        for (int i = 0; i < 4 * MaxSteps; i++)
            stepData[i] = 8'h80 | 8'(i);
        $readmemh("tests/snakeInput.txt", stepData);
        stepCount = 0;
        while (stepCount < MaxSteps && stepData[4*stepCount] < 8'h80)
            stepCount++;
        if (stepCount == 0)
        begin
            $display("no steps could be read from tests/snakeInput.txt");
            errorCount++;
        end
        stepsLoaded = 1'b1;
    endtask

    // returns on the falling edge that shows the first write of a pass
    task automatic waitForPlot();
        do
            @(negedge Clock);
        while (!plot);
    endtask

    task automatic capturePass(input int count);
        for (int i = 0; i < count; i++)
        begin
            if (i > 0)
                @(negedge Clock);
            if (!plot)
            begin
                $display("pass interrupted: plot low at write %0d of %0d", i, count);
                errorCount++;
            end
            capX[i] = pixel.x;
            capY[i] = pixel.y;
            capC[i] = pixel.colour;
        end
    endtask

    // one tile in row-major order from its origin
    task automatic checkTile(input int base, input int originX, input int originY,
                             input int colour);
        int idx;
        for (int row = 0; row < TileSize; row++)
        begin
            for (int col = 0; col < TileSize; col++)
            begin
                idx = base + row * TileSize + col;
                checkValue("pixel.x", capX[idx], originX + col);
                checkValue("pixel.y", capY[idx], originY + row);
                checkValue("pixel.colour", capC[idx], colour);
            end
        end
    endtask

    task automatic checkSnake(input int base, input int colour);
        for (int k = 0; k < SnakeLength; k++)
            checkTile(base + k * TilePixels, tileX[k], tileY[k], colour);
    endtask

    // apple tile then six segments
    task automatic checkDrawPass();
        waitForPlot();
        capturePass(TilePixels * (SnakeLength + 1));
        checkTile(0, AppleOrigin.x, AppleOrigin.y, AppleColour);
        checkSnake(TilePixels, snakeColour);
    endtask

    task automatic driveHeading(input int delayCycles, input logic [1:0] heading);
        repeat (delayCycles + 1) @(posedge Clock);
        #2;
        dirValid = 1'b1;
        dirReq = directionT'(heading);
        @(posedge Clock);
        #2;
        dirValid = 1'b0;
    endtask

    task automatic waitForGameOver();
        int waited;
        waited = 0;
        // check cycle follows the last erase write directly
        while (!gameOver && waited < 16)
        begin
            @(negedge Clock);
            waited++;
        end
        if (!gameOver)
        begin
            $display("gameOver did not rise after the colliding erase pass");
            errorCount++;
        end
    endtask

    // a new start must not wake the engine
    task automatic checkStopped();
        @(posedge Clock);
        #2;
        start = 1'b1;
        @(posedge Clock);
        #2;
        start = 1'b0;
        repeat (2 * TickPeriod)
        begin
            @(negedge Clock);
            checkValue("plot", plot, 1'b0);
            checkValue("gameOver", gameOver, 1'b1);
        end
    endtask

    initial
    begin
        wait (stepsLoaded);
        watchdogCycles = (stepCount + 2) * 3 * TickPeriod;
        repeat (watchdogCycles) @(posedge Clock);
        $display("timeout: run still busy after %0d cycles", watchdogCycles);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        int strobeAt;
        logic finished;
        void'($urandom(7));
        reset = 1'b1;
        start = 1'b0;
        dirValid = 1'b0;
        dirReq = DirUp;
        // never black so body and erase differ
        snakeColour = colourT'(1 + $urandom % 7);
        finished = 1'b0;
        loadSteps();
        for (int k = 0; k < SnakeLength; k++)
        begin
            tileX[k] = StartHead.x;
            tileY[k] = StartHead.y + TileSize * k;
        end
        repeat (2) @(posedge Clock);
        #2;
        reset = 1'b0;

        // quiet until started
        repeat (3000)
        begin
            @(negedge Clock);
            checkValue("plot", plot, 1'b0);
            checkValue("gameOver", gameOver, 1'b0);
        end
        @(posedge Clock);
        #2;
        start = 1'b1;
        @(posedge Clock);
        #2;
        start = 1'b0;
        checkDrawPass();

        for (int i = 0; i < stepCount && !finished; i++)
        begin
            strobeAt = $urandom % 500;
            waitForPlot();
            // heading request lands somewhere inside the erase pass
            fork
                capturePass(TilePixels * SnakeLength);
                driveHeading(strobeAt, stepData[4*i][1:0]);
            join
            checkSnake(0, EraseColour);
            if (stepData[4*i+3] != 8'h00)
            begin
                waitForGameOver();
                checkStopped();
                finished = 1'b1;
            end
            else
            begin
                // shift toward the tail and take the new head from the file
                for (int k = SnakeLength - 1; k > 0; k--)
                begin
                    tileX[k] = tileX[k-1];
                    tileY[k] = tileY[k-1];
                end
                tileX[0] = stepData[4*i+1];
                tileY[0] = stepData[4*i+2];
                checkDrawPass();
                checkValue("gameOver", gameOver, 1'b0);
            end
        end

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- flist.f
verilog/snakeGeomPkg.sv
verilog/snakeCtrlPkg.sv
verilog/frameTimer.sv
verilog/tileScanner.sv
verilog/snakeBody.sv
verilog/tilePainter.sv
verilog/snakeSequencer.sv
verilog/snakeGame.sv
tests/snakeGameTb.sv

//--- Bender.yml
package:
  name: snake_game

sources:
  - verilog/snakeGeomPkg.sv
  - verilog/snakeCtrlPkg.sv
  - verilog/frameTimer.sv
  - verilog/tileScanner.sv
  - verilog/snakeBody.sv
  - verilog/tilePainter.sv
  - verilog/snakeSequencer.sv
  - verilog/snakeGame.sv
  - target: test
    files:
      - tests/snakeGameTb.sv

//--- tests/snakeInput.txt
// heading (0 up, 1 down, 2 left, 3 right), expected head x, expected head y, expected gameOver
// all hex, one step per line, head columns unused on the colliding step
0 50 32 0
0 50 28 0
2 46 28 0
2 3c 28 0
1 3c 32 0
3 46 32 0
3 50 32 0
0 50 28 0
0 50 1e 0
0 50 14 0
0 50 0a 0
0 50 00 0
1 50 00 1
